/* common/posit_macros.svh */
`ifndef POSIT_MACROS_SVH
`define POSIT_MACROS_SVH

// Posit format
`define POSIT_N   16
`define POSIT_ES  3
`define POSIT_BS  4          // Regime count width, log2(N)
`define POSIT_M   13         // N - es

// Reciprocal
`define SEED_AW   4          // Seed table address width
`define NR_STEPS  2

// Start to done in clock cycles
`define DIV_LAT   4

`endif

/* common/posit_pkg.sv */
`default_nettype none

`include "posit_macros.svh"

package posit_pkg;

	typedef struct packed {
		logic signed [`POSIT_BS+1:0] rgm;   // Signed regime part
		logic [`POSIT_ES-1:0]        exp;
	} scale_fld_t;

	// Scale of the quotient, subtracted as one number and split into regime/exponent
	typedef union packed {
		logic signed [`POSIT_BS+`POSIT_ES+1:0] val;
		scale_fld_t                            fld;
	} scale_u;

	typedef logic [`SEED_AW:0] seed_t;  // Top bit weighs 1/2

	typedef seed_t [2**`SEED_AW-1:0] seed_tbl_t;

	////////////////////////////////////////////////////////////
	// Seed entry a holds 1/(1 + (a + 0.5) / 2^AW), scaled by 2^(AW+1)
	////////////////////////////////////////////////////////////
	function automatic seed_tbl_t make_seed_table();
		seed_tbl_t tbl;
		int        den;
		for (int a = 0; a < 2**`SEED_AW; a++) begin
			den    = 2**(`SEED_AW+1) + 1 + 2*a;
			tbl[a] = seed_t'((2**(2*`SEED_AW+2) + den/2) / den);   // Round to nearest
		end
		return tbl;
	endfunction

endpackage

`default_nettype wire

/* common/div_stage_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "posit_macros.svh"

// One division in flight between two pipeline stages
interface div_stage_if ();

	logic                     vld;
	logic                     sgn;          // Quotient sign
	logic                     inf;
	logic                     zero;
	posit_pkg::scale_u        scl;
	logic [`POSIT_M:0]        m1;           // Dividend mantissa, hidden bit on top
	logic [`POSIT_M:0]        m2;           // Divisor mantissa, hidden bit on top
	logic [2*`POSIT_M+1:0]    inv;          // Reciprocal, later the quotient mantissa
	logic                     m2_frac_zero;

	modport source (
		output vld, sgn, inf, zero, scl, m1, m2, inv, m2_frac_zero
	);

	modport sink (
		input vld, sgn, inf, zero, scl, m1, m2, inv, m2_frac_zero
	);

endinterface

`default_nettype wire

/* posit_div/posit_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "posit_macros.svh"

module posit_decode (
	input  logic                 clk,
	input  logic                 arst_n_i,
	input  logic                 start_i,
	input  logic [`POSIT_N-1:0]  in1_i,
	input  logic [`POSIT_N-1:0]  in2_i,
	div_stage_if.source          dst
);

	logic [1:0][`POSIT_N-1:0]  op;
	logic [1:0]                s;
	logic [1:0]                nz;      // Any bit below the sign
	logic [1:0]                nar;
	logic [1:0]                zro;
	logic [1:0][`POSIT_BS+1:0] r;
	logic [1:0][`POSIT_ES-1:0] e;
	logic [1:0][`POSIT_M-1:0]  mant;
	posit_pkg::scale_u         scl_d;

	assign op = {in2_i, in1_i};

	////////////////////////////////////////////////////////////
	// Field extraction, same for both operands
	////////////////////////////////////////////////////////////
	always_comb begin
		logic [`POSIT_N-1:0]  xin;
		logic [`POSIT_N-1:0]  xin_r;
		logic [`POSIT_N-1:0]  lod_in;
		logic [`POSIT_N-1:0]  xs;
		logic                 rc;
		logic [`POSIT_BS-1:0] k;
		logic [`POSIT_BS-1:0] regime;
		int                   k_i;
		for (int j = 0; j < 2; j++) begin
			s[j]   = op[j][`POSIT_N-1];
			nz[j]  = |op[j][`POSIT_N-2:0];
			nar[j] = s[j] & ~nz[j];
			zro[j] = ~(s[j] | nz[j]);

			xin    = s[j] ? -op[j] : op[j];          // Two's-complement magnitude
			rc     = xin[`POSIT_N-2];                // Regime run of ones or zeros
			xin_r  = rc ? ~xin : xin;
			lod_in = {xin_r[`POSIT_N-2:0], rc};

			// Leading-one position from the top, the highest set bit wins
			k_i = `POSIT_N - 1;
			for (int b = 0; b < `POSIT_N; b++) begin
				if (lod_in[b]) begin
					k_i = `POSIT_N - 1 - b;
				end
			end
			k = k_i[`POSIT_BS-1:0];

			regime = rc ? k - 1'b1 : k;
			r[j]   = rc ? {2'b00, regime} : -{2'b00, regime};

			xs      = {xin[`POSIT_N-3:0], 2'b00} << k;   // Drop the run
			e[j]    = xs[`POSIT_N-1 -: `POSIT_ES];
			mant[j] = xs[`POSIT_M-1:0];
		end
	end

	assign scl_d.val = {r[0], e[0]} - {r[1], e[1]};   // Borrow comes in stage 3

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			dst.vld <= 1'b0;
		end else begin
			dst.vld <= start_i;
		end
	end

	always_ff @(posedge clk) begin
		if (start_i) begin
			dst.sgn          <= s[0] ^ s[1];
			dst.inf          <= nar[0] | zro[1];   // NaR / x or x / 0
			dst.zero         <= zro[0] | nar[1];   // 0 / x or x / NaR
			dst.scl          <= scl_d;
			dst.m1           <= {nz[0], mant[0]};
			dst.m2           <= {nz[1], mant[1]};
			dst.inv          <= '0;                // Seed lookup follows
			dst.m2_frac_zero <= ~|mant[1];
		end
	end

endmodule

`default_nettype wire

/* posit_div/posit_recip.sv */
`timescale 1ns/1ps
`default_nettype none

`include "posit_macros.svh"

module posit_recip (
	input  logic        clk,
	input  logic        arst_n_i,
	div_stage_if.sink   src,
	div_stage_if.source dst
);

	localparam posit_pkg::seed_tbl_t SEED_TBL = posit_pkg::make_seed_table();

	posit_pkg::seed_t         seed;
	logic [`POSIT_M:0]        a0;      // Seed aligned to the mantissa width
	logic [2*`POSIT_M+1:0]    p0;
	logic [`POSIT_M+1:0]      t0;
	logic [2*`POSIT_M+1:0]    inv1;

	assign seed = SEED_TBL[src.m2[`POSIT_M-1 -: `SEED_AW]];
	assign a0   = {seed, {(`POSIT_M-`SEED_AW){1'b0}}};

	////////////////////////////////////////////////////////////
	// First Newton-Raphson step, x1 = x0 * (2 - x0 * d)
	////////////////////////////////////////////////////////////
	assign p0 = a0 * src.m2;   // Weight 1 at the top bit
	assign t0 = {2'b01, {`POSIT_M{1'b0}}}
		- {2'b00, p0[2*`POSIT_M+1:`POSIT_M+3], |p0[`POSIT_M+2:0]};
	assign inv1 = a0 * {t0[`POSIT_M-1:0], 1'b0};

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			dst.vld <= 1'b0;
		end else begin
			dst.vld <= src.vld;
		end
	end

	always_ff @(posedge clk) begin
		if (src.vld) begin
			dst.sgn          <= src.sgn;
			dst.inf          <= src.inf;
			dst.zero         <= src.zero;
			dst.scl          <= src.scl;
			dst.m1           <= src.m1;
			dst.m2           <= src.m2;
			dst.inv          <= inv1;   // Weight 1/2 at bit 2M
			dst.m2_frac_zero <= src.m2_frac_zero;
		end
	end

endmodule

`default_nettype wire

/* posit_div/posit_quot.sv */
`timescale 1ns/1ps
`default_nettype none

`include "posit_macros.svh"

module posit_quot (
	input  logic        clk,
	input  logic        arst_n_i,
	div_stage_if.sink   src,
	div_stage_if.source dst
);

	logic [`POSIT_M:0]        a1;
	logic [2*`POSIT_M+1:0]    p1;
	logic [`POSIT_M+1:0]      t1;
	logic [2*`POSIT_M+1:0]    inv2;
	logic [2*`POSIT_M+1:0]    div_m;
	logic [2*`POSIT_M+1:0]    div_mn;
	logic                     udf;
	logic                     bin;
	posit_pkg::scale_u        scl_d;

	// Last step widens the estimate by another seed width
	assign a1 = {src.inv[2*`POSIT_M -: `SEED_AW*`NR_STEPS+1],
		{(`POSIT_M-`SEED_AW*`NR_STEPS){1'b0}}};
	assign p1 = a1 * src.m2;
	assign t1 = {2'b01, {`POSIT_M{1'b0}}}
		- {2'b00, p1[2*`POSIT_M+1:`POSIT_M+3], |p1[`POSIT_M+2:0]};
	assign inv2 = a1 * {t1[`POSIT_M-1:0], 1'b0};

	// Divisor 1.0 needs no reciprocal
	assign div_m = src.m2_frac_zero ? {1'b0, src.m1, {`POSIT_M{1'b0}}}
		: src.m1 * inv2[2*`POSIT_M:`POSIT_M];

	////////////////////////////////////////////////////////////
	// Normalize, quotient >= 1 already sits in the top bit
	////////////////////////////////////////////////////////////
	assign udf    = div_m[2*`POSIT_M+1];
	assign div_mn = udf ? div_m : div_m << 1;
	assign bin    = ~(src.m2_frac_zero | udf);

	assign scl_d.val = src.scl.val - bin;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			dst.vld <= 1'b0;
		end else begin
			dst.vld <= src.vld;
		end
	end

	always_ff @(posedge clk) begin
		if (src.vld) begin
			dst.sgn          <= src.sgn;
			dst.inf          <= src.inf;
			dst.zero         <= src.zero;
			dst.scl          <= scl_d;
			dst.m1           <= src.m1;
			dst.m2           <= src.m2;
			dst.inv          <= div_mn;   // Quotient mantissa from here on
			dst.m2_frac_zero <= src.m2_frac_zero;
		end
	end

endmodule

`default_nettype wire

/* posit_div/posit_encode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "posit_macros.svh"

module posit_encode (
	input  logic                 clk,
	input  logic                 arst_n_i,
	div_stage_if.sink            src,
	output logic [`POSIT_N-1:0]  out_o,
	output logic                 inf_o,
	output logic                 zero_o,
	output logic                 done_o
);

	posit_pkg::scale_u         scl;
	logic [2*`POSIT_M+1:0]     qm;
	logic                      neg;       // Scale below zero
	logic [`POSIT_BS+1:0]      r_full;
	logic [`POSIT_BS:0]        r_o;
	logic [`POSIT_BS-1:0]      sh;
	logic [2*`POSIT_N+2:0]     tmp_o;
	logic [3*`POSIT_N+2:0]     tmp1_o;
	logic                      l_bit;
	logic                      g_bit;
	logic                      r_bit;
	logic                      s_bit;
	logic                      ulp;
	logic [`POSIT_N-1:0]       keep;
	logic [`POSIT_N-1:0]       rounded;
	logic [`POSIT_N-1:0]       res;
	logic [`POSIT_N-1:0]       out_d;

	assign scl = src.scl;
	assign qm  = src.inv;
	assign neg = scl.fld.rgm[`POSIT_BS+1];

	// Run length, the exponent bits never change it
	assign r_full = neg ? -scl.fld.rgm : scl.fld.rgm + 1'b1;
	assign r_o    = r_full[`POSIT_BS:0];
	assign sh     = r_o[`POSIT_BS] ? '1 : r_o[`POSIT_BS-1:0];   // Saturate

	////////////////////////////////////////////////////////////
	// Pack run, terminator, exponent, fraction and G/R/S, then shift the regime in
	////////////////////////////////////////////////////////////
	assign tmp_o = {{`POSIT_N{~neg}}, neg, scl.fld.exp,
		qm[2*`POSIT_M -: `POSIT_N-`POSIT_ES-1],
		qm[2*`POSIT_M-(`POSIT_N-`POSIT_ES-1) -: 2],
		|qm[2*`POSIT_M-(`POSIT_N-`POSIT_ES-1)-2:0]};
	assign tmp1_o = {tmp_o, {`POSIT_N{1'b0}}} >> sh;

	// Round to nearest even
	assign l_bit = tmp1_o[`POSIT_N+4];
	assign g_bit = tmp1_o[`POSIT_N+3];
	assign r_bit = tmp1_o[`POSIT_N+2];
	assign s_bit = |tmp1_o[`POSIT_N+1:0];
	assign ulp   = g_bit & (r_bit | s_bit | l_bit);

	assign keep    = tmp1_o[2*`POSIT_N+2:`POSIT_N+3];
	assign rounded = (r_o < `POSIT_M-2) ? keep + ulp : keep;   // Long regimes are not rounded
	assign res     = src.sgn ? -rounded : rounded;

	always_comb begin
		if (src.inf | src.zero | ~qm[2*`POSIT_M+1]) begin
			out_d = {src.inf, {(`POSIT_N-1){1'b0}}};   // NaR or zero
		end else begin
			out_d = {src.sgn, res[`POSIT_N-1:1]};
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			done_o <= 1'b0;
			out_o  <= '0;
			inf_o  <= 1'b0;
			zero_o <= 1'b0;
		end else begin
			done_o <= src.vld;
			if (src.vld) begin   // Result holds until the next one
				out_o  <= out_d;
				inf_o  <= src.inf;
				zero_o <= src.zero;
			end
		end
	end

endmodule

`default_nettype wire

/* posit_div/posit_div.sv */
`timescale 1ns/1ps
`default_nettype none

`include "posit_macros.svh"

// Four-stage posit divider, one result per cycle
module posit_div (
	input  logic                 clk,
	input  logic                 arst_n_i,
	input  logic                 start_i,
	input  logic [`POSIT_N-1:0]  in1_i,     // Dividend
	input  logic [`POSIT_N-1:0]  in2_i,     // Divisor
	output logic [`POSIT_N-1:0]  out_o,
	output logic                 inf_o,
	output logic                 zero_o,
	output logic                 done_o
);

	div_stage_if s12 ();
	div_stage_if s23 ();
	div_stage_if s34 ();

	posit_decode i_decode (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.start_i  (start_i),
		.in1_i    (in1_i),
		.in2_i    (in2_i),
		.dst      (s12)
	);

	posit_recip i_recip (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.src      (s12),
		.dst      (s23)
	);

	posit_quot i_quot (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.src      (s23),
		.dst      (s34)
	);

	posit_encode i_encode (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.src      (s34),
		.out_o    (out_o),
		.inf_o    (inf_o),
		.zero_o   (zero_o),
		.done_o   (done_o)
	);

endmodule

`default_nettype wire

/* verif/posit_div_props.sv */
`timescale 1ns/1ps
`default_nettype none

`include "posit_macros.svh"

// Handshake and special-output properties of the divider
module posit_div_props (
	input logic                 clk,
	input logic                 arst_n_i,
	input logic                 start_i,
	input logic [`POSIT_N-1:0]  in1_i,
	input logic [`POSIT_N-1:0]  in2_i,
	input logic [`POSIT_N-1:0]  out_o,
	input logic                 inf_o,
	input logic                 zero_o,
	input logic                 done_o
);

	logic both_special;   // Neither operand carries bits below the sign
	int   fail_cnt = 0;

	assign both_special = ~|in1_i[`POSIT_N-2:0] & ~|in2_i[`POSIT_N-2:0];

	done_latency: assert property (@(posedge clk) disable iff (!arst_n_i)
		done_o == $past(start_i, `DIV_LAT))
		else begin
			$error("done_o does not follow start_i by the pipeline latency");
			fail_cnt++;
		end

	flags_exclusive: assert property (@(posedge clk) disable iff (!arst_n_i)
		(done_o && inf_o && zero_o) |-> $past(both_special, `DIV_LAT))
		else begin
			$error("inf_o and zero_o both high for operands that are not both special");
			fail_cnt++;
		end

	nar_pattern: assert property (@(posedge clk) disable iff (!arst_n_i)
		inf_o |-> (out_o == {1'b1, {(`POSIT_N-1){1'b0}}}))
		else begin
			$error("inf_o high without the NaR output pattern");
			fail_cnt++;
		end

endmodule

bind posit_div posit_div_props i_props (.*);

`default_nettype wire

/* verif/tb_posit_div.sv */
`timescale 1ns/1ps
`default_nettype none

`include "posit_macros.svh"

module tb_posit_div;

	localparam int SEED0   = 32'h343;
	localparam int N_RAND  = 500;
	localparam int TIMEOUT = 200;   // Cycles

	logic                clk;
	logic                arst_n_i;
	logic                start_i;
	logic [`POSIT_N-1:0] in1_i;
	logic [`POSIT_N-1:0] in2_i;
	logic [`POSIT_N-1:0] out_o;
	logic                inf_o;
	logic                zero_o;
	logic                done_o;

	int seed;
	int errors;
	int checks;
	int cur_test;
	int start_cnt;
	int done_cnt;
	int cyc;
	int err_before;

	// Expected results in issue order
	logic [`POSIT_N-1:0] exp_q[$];
	logic                inf_q[$];
	logic                zero_q[$];
	logic [`POSIT_N-1:0] a_q[$];
	logic [`POSIT_N-1:0] b_q[$];
	int                  mode_q[$];   // 0 exact, 1 within one ulp
	int                  cyc_q[$];
	int                  test_q[$];

	posit_div i_posit_div (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.start_i  (start_i),
		.in1_i    (in1_i),
		.in2_i    (in2_i),
		.out_o    (out_o),
		.inf_o    (inf_o),
		.zero_o   (zero_o),
		.done_o   (done_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic string test_name(input int t);
		case (t)
			1:       return "reset";
			2:       return "special_cases";
			3:       return "exact_quotients";
			4:       return "random_pairs";
			5:       return "back_to_back";
			default: return "idle_gaps";
		endcase
	endfunction

	function automatic real pow2(input int n);
		real r;
		r = 1.0;
		for (int i = 0; i < n; i++) r = r * 2.0;
		for (int i = 0; i > n; i--) r = r / 2.0;
		return r;
	endfunction

	////////////////////////////////////////////////////////////
	// Reference posit model, N = 16, es = 3
	////////////////////////////////////////////////////////////
	function automatic real posit_to_real(input logic [15:0] p);
		logic [15:0] x;
		logic        rc;
		int          m;
		int          i;
		int          k;
		int          e;
		int          pos;
		real         f;
		real         w;
		real         v;
		if (p[14:0] == 15'd0) return 0.0;
		x  = p[15] ? -p : p;
		rc = x[14];
		m  = 0;
		i  = 14;
		while (i >= 0 && x[i] == rc) begin
			m++;
			i--;
		end
		k   = rc ? m - 1 : -m;
		pos = i - 1;              // First bit after the terminator
		e   = 0;
		for (int t = 0; t < 3; t++) begin
			e = e * 2;
			if (pos - t >= 0 && x[pos-t]) e++;
		end
		f = 0.0;
		w = 0.5;
		for (int j = pos - 3; j >= 0; j--) begin
			if (x[j]) f = f + w;
			w = w / 2.0;
		end
		v = pow2(8 * k + e) * (1.0 + f);   // useed = 256
		return p[15] ? -v : v;
	endfunction

	// Nearest posit by value, ties to the even pattern, saturating
	function automatic logic [15:0] real_to_posit(input real q);
		logic        neg;
		real         a;
		real         vl;
		real         vh;
		int          lo;
		int          hi;
		int          mid;
		logic [15:0] p;
		if (q == 0.0) return 16'h0000;
		neg = q < 0.0;
		a   = neg ? -q : q;
		lo  = 1;
		hi  = 32767;
		if (a <= posit_to_real(16'h0001)) begin
			p = 16'h0001;
		end else if (a >= posit_to_real(16'h7fff)) begin
			p = 16'h7fff;
		end else begin
			while (hi - lo > 1) begin
				mid = (lo + hi) / 2;
				if (posit_to_real(16'(mid)) <= a) lo = mid;
				else hi = mid;
			end
			vl = posit_to_real(16'(lo));
			vh = posit_to_real(16'(hi));
			if (a - vl < vh - a) p = 16'(lo);
			else if (a - vl > vh - a) p = 16'(hi);
			else p = lo[0] ? 16'(hi) : 16'(lo);
		end
		return neg ? -p : p;
	endfunction

	////////////////////////////////////////////////////////////
	// Monitor, samples on the falling edge where everything is stable
	////////////////////////////////////////////////////////////
	task automatic push_expected();
		logic ei;
		logic ez;
		ei = (in1_i == 16'h8000) | (in2_i == 16'h0000);
		ez = (in1_i == 16'h0000) | (in2_i == 16'h8000);
		inf_q.push_back(ei);
		zero_q.push_back(ez);
		if (ei) exp_q.push_back(16'h8000);
		else if (ez) exp_q.push_back(16'h0000);
		else exp_q.push_back(real_to_posit(posit_to_real(in1_i) / posit_to_real(in2_i)));
		a_q.push_back(in1_i);
		b_q.push_back(in2_i);
		mode_q.push_back((cur_test >= 4) ? 1 : 0);
		cyc_q.push_back(cyc);
		test_q.push_back(cur_test);
		start_cnt++;
	endtask

	task automatic check_result();
		logic [15:0] e;
		logic [15:0] a;
		logic [15:0] b;
		logic        ei;
		logic        ez;
		int          m;
		int          c;
		int          t;
		int          diff;
		done_cnt++;   // Every pulse, matched or not
		assert (exp_q.size() > 0) else begin
			$display("done_o raised with no start pending");
			errors++;
		end
		if (exp_q.size() > 0) begin
			e  = exp_q.pop_front();
			ei = inf_q.pop_front();
			ez = zero_q.pop_front();
			a  = a_q.pop_front();
			b  = b_q.pop_front();
			m  = mode_q.pop_front();
			c  = cyc_q.pop_front();
			t  = test_q.pop_front();
			checks++;
			assert (cyc - c == `DIV_LAT) else begin
				$display("Error %s latency: expected %0d actual %0d",
					test_name(t), `DIV_LAT, cyc - c);
				errors++;
			end
			assert (inf_o == ei && zero_o == ez) else begin
				$display("Error %s flags %h/%h: expected inf %b zero %b actual inf %b zero %b",
					test_name(t), a, b, ei, ez, inf_o, zero_o);
				errors++;
			end
			diff = int'($signed(out_o)) - int'($signed(e));
			if (m == 0 || ei || ez) begin
				assert (out_o == e) else begin
					$display("Error %s %h/%h: expected %h actual %h",
						test_name(t), a, b, e, out_o);
					errors++;
				end
			end else begin
				assert (out_o[15] == e[15] && diff <= 1 && diff >= -1) else begin
					$display("Error %s %h/%h: expected %h (one ulp) actual %h",
						test_name(t), a, b, e, out_o);
					errors++;
				end
			end
		end
	endtask

	always @(negedge clk) begin
		cyc = cyc + 1;
		if (arst_n_i && start_i) push_expected();
		if (arst_n_i && done_o) check_result();
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////
	task automatic issue(input logic [15:0] a, input logic [15:0] b);
		@(posedge clk);
		start_i <= 1'b1;
		in1_i   <= a;
		in2_i   <= b;
	endtask

	task automatic idle(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			start_i <= 1'b0;
		end
	endtask

	task automatic drain();
		int w;
		w = 0;
		idle(1);
		while (exp_q.size() > 0 && w < TIMEOUT) begin
			@(posedge clk);
			w++;
		end
		if (exp_q.size() > 0) begin
			$display("Timeout while waiting for %0d pending results", exp_q.size());
			$display("SIMULATION FAILED");
			$finish;
		end
	endtask

	function automatic logic [15:0] random_operand();
		logic [31:0] r;
		r = $random(seed);
		if (r[14:0] == 15'd0) r[0] = 1'b1;   // Keep it finite and nonzero
		return r[15:0];
	endfunction

	task automatic report_test(input int t);
		if (errors == err_before) $display("Test %0d %s: ok", t, test_name(t));
		else $display("Test %0d %s: %0d errors", t, test_name(t), errors - err_before);
	endtask

	task automatic check_idle_outputs();
		checks++;
		assert (!done_o && !inf_o && !zero_o && out_o == 16'h0000) else begin
			$display("Error reset: expected 0000 actual %h (done %b inf %b zero %b)",
				out_o, done_o, inf_o, zero_o);
			errors++;
		end
	endtask

	initial begin
		logic [15:0] sp[4];
		logic [15:0] x;
		int          gap;
		seed      = SEED0;
		errors    = 0;
		checks    = 0;
		start_cnt = 0;
		done_cnt  = 0;
		cyc       = 0;
		arst_n_i  = 1'b0;
		start_i   = 1'b0;
		in1_i     = '0;
		in2_i     = '0;

		cur_test   = 1;
		err_before = errors;
		for (int i = 0; i < 4; i++) begin
			@(posedge clk);
			#1 check_idle_outputs();
		end
		@(posedge clk);
		arst_n_i <= 1'b1;
		@(negedge clk);
		check_idle_outputs();
		report_test(1);

		// Zero, NaR and finite values on both sides
		cur_test   = 2;
		err_before = errors;
		sp         = '{16'h0000, 16'h8000, 16'h4000, 16'hc800};
		for (int i = 0; i < 4; i++) begin
			for (int j = 0; j < 4; j++) begin
				if (i < 2 || j < 2) issue(sp[i], sp[j]);
			end
		end
		drain();
		report_test(2);

		cur_test   = 3;
		err_before = errors;
		for (int i = 0; i < 16; i++) begin
			x = 16'h4000 | (16'(1 + i % 7) << 10) | (random_operand() & 16'h03ff);
			issue(x, 16'h4400);     // Divide by 2.0
			issue(-x, 16'h4000);    // Divide by 1.0
		end
		issue(16'h4800, 16'h4800);
		issue(-16'h4400, 16'h4400);
		issue(16'h3c00, -16'h3c00);
		drain();
		report_test(3);

		cur_test   = 4;
		err_before = errors;
		for (int i = 0; i < N_RAND; i++) begin
			issue(random_operand(), random_operand());
			idle(1);
		end
		drain();
		report_test(4);

		cur_test   = 5;
		err_before = errors;
		for (int i = 0; i < 64; i++) issue(random_operand(), random_operand());
		drain();
		report_test(5);

		cur_test   = 6;
		err_before = errors;
		for (int i = 0; i < 100; i++) begin
			issue(random_operand(), random_operand());
			gap = $random(seed) & 3;
			if (gap > 0) idle(gap);
		end
		drain();
		checks++;
		assert (done_cnt == start_cnt) else begin
			$display("Error idle_gaps pulse count: expected %0d actual %0d",
				start_cnt, done_cnt);
			errors++;
		end
		report_test(6);

		if (i_posit_div.i_props.fail_cnt != 0) begin
			$display("Bound assertions failed %0d times", i_posit_div.i_props.fail_cnt);
			errors = errors + i_posit_div.i_props.fail_cnt;
		end

		$display("Tests 6, checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+common
common/posit_pkg.sv
common/div_stage_if.sv
posit_div/posit_decode.sv
posit_div/posit_recip.sv
posit_div/posit_quot.sv
posit_div/posit_encode.sv
posit_div/posit_div.sv
verif/posit_div_props.sv
verif/tb_posit_div.sv

/* run.sh */
#!/bin/sh
# Build and run with Verilator, then decide on the log
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_posit_div -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1 ; cat sim.log \
	&& ! grep -q "SIMULATION FAILED" sim.log \
	&& grep -q "SIMULATION PASSED" sim.log \
	|| exit 1
